// ==== rtl/cu_defs.svh ====
`ifndef CU_DEFS_SVH
`define CU_DEFS_SVH

// instruction field widths
`define CU_TYPE_W 4
`define CU_K_W 4
`define CU_S_W 4

// full instruction word
// type + kernel + stride + relu + pool + 2 spare
`define CU_INST_W 16

// feature-map side length, low bits of a set-dim word
`define CU_DIM_W 12

// side length held after reset
`define CU_DIM_INIT 28

// instruction queue depth, power of two
`define CU_FIFO_DEPTH 4

`endif

// ==== rtl/cu_pkg.sv ====
`default_nettype none
`include "cu_defs.svh"

package cu_pkg;

  typedef logic [`CU_DIM_W-1:0] dim_t;
  typedef logic [`CU_K_W-1:0]   kern_t;
  typedef logic [`CU_S_W-1:0]   stride_t;

  // layer codes, 5..14 are pending types and decode as illegal
  typedef enum logic [`CU_TYPE_W-1:0] {
    lt_conv    = 4'd0,
    lt_pool    = 4'd1,
    lt_relu    = 4'd2,
    lt_fc      = 4'd3,
    lt_bypass  = 4'd4,
    lt_set_dim = 4'd15
  } layer_type_e;

  //////////////////////////////
  // instruction word views
  //////////////////////////////

  // layer word, msb first
  typedef struct packed {
    layer_type_e layer_type;
    kern_t       kernel;
    stride_t     stride;
    logic        relu_en;
    logic        pool_en;
    logic [`CU_INST_W-`CU_TYPE_W-`CU_K_W-`CU_S_W-3:0] spare;
  } layer_fields_s;

  // set-dim word, new side length in the low bits
  typedef struct packed {
    layer_type_e layer_type;
    dim_t        dim;
  } dim_fields_s;

  typedef union packed {
    layer_fields_s layer;
    dim_fields_s   dim;
  } inst_u;

  //////////////////////////////
  // stage commands
  //////////////////////////////

  // decode -> shape, stride never 0 here
  typedef struct packed {
    logic        is_set_dim;
    logic        illegal;
    layer_type_e layer_type;
    kern_t       kernel;
    stride_t     stride;
    logic        relu_en;
    logic        pool_en;
    dim_t        dim;
  } dec_cmd_s;

  // shape -> compute engines
  typedef struct packed {
    layer_type_e layer_type;
    kern_t       kernel;
    stride_t     stride;
    logic        relu_en;
    logic        pool_en;
    logic        illegal;
    logic        shape_err;
    dim_t        in_dim;
    dim_t        out_dim;
  } layer_cmd_s;

endpackage

`default_nettype wire

// ==== rtl/cu_inst_fifo.sv ====
`default_nettype none
`include "cu_defs.svh"

module cu_inst_fifo (
  input  logic          clk,
  input  logic          rst,
  input  logic          in_valid,
  output logic          in_ready,
  input  cu_pkg::inst_u in_word,
  output logic          out_valid,
  input  logic          out_ready,
  output cu_pkg::inst_u out_word
);

  import cu_pkg::*;

  localparam int aw = $clog2(`CU_FIFO_DEPTH);
  localparam logic [aw:0] full_cnt = `CU_FIFO_DEPTH;

  // word storage
  inst_u mem [`CU_FIFO_DEPTH];

  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  // one extra bit so full and empty differ
  logic [aw:0]   count;

  logic push;
  logic pop;

  //////////////////////////////
  // handshake
  //////////////////////////////

  // host may push until every slot holds a word
  assign in_ready  = (count != full_cnt);
  assign out_valid = (count != '0);
  assign out_word  = mem[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  //////////////////////////////
  // storage and pointers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_word;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop keeps the count
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cu_inst_decode.sv ====
`default_nettype none
`include "cu_defs.svh"

module cu_inst_decode (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  output logic             in_ready,
  input  cu_pkg::inst_u    in_word,
  output logic             out_valid,
  input  logic             out_ready,
  output cu_pkg::dec_cmd_s out_cmd
);

  import cu_pkg::*;

  dec_cmd_s nxt_cmd;
  logic     legal;
  logic     accept;

  //////////////////////////////
  // field decode
  //////////////////////////////

  // type field sits in the same bits in both views
  always_comb begin
    case (in_word.layer.layer_type)
      lt_conv, lt_pool, lt_relu, lt_fc, lt_bypass, lt_set_dim: begin
        legal = 1'b1;
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  always_comb begin
    nxt_cmd = '0;
    if (in_word.layer.layer_type == lt_set_dim) begin
      // dim view, no layer fields
      nxt_cmd.is_set_dim = 1'b1;
      nxt_cmd.layer_type = in_word.dim.layer_type;
      nxt_cmd.dim        = in_word.dim.dim;
    end else begin
      // layer view, pending codes keep their fields
      nxt_cmd.illegal    = ~legal;
      nxt_cmd.layer_type = in_word.layer.layer_type;
      nxt_cmd.kernel     = in_word.layer.kernel;
      nxt_cmd.relu_en    = in_word.layer.relu_en;
      nxt_cmd.pool_en    = in_word.layer.pool_en;
      // stride 0 treated as 1
      if (in_word.layer.stride == '0) begin
        nxt_cmd.stride = stride_t'(1);
      end else begin
        nxt_cmd.stride = in_word.layer.stride;
      end
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  // take a new word when empty or when the held one leaves now
  assign in_ready = ~out_valid | out_ready;
  assign accept   = in_valid & in_ready;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_cmd <= nxt_cmd;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cu_shape_calc.sv ====
`default_nettype none
`include "cu_defs.svh"

module cu_shape_calc (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  output logic               in_ready,
  input  cu_pkg::dec_cmd_s   in_cmd,
  output logic               out_valid,
  input  logic               out_ready,
  output cu_pkg::layer_cmd_s out_cmd
);

  import cu_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_divide,
    st_hold
  } state_e;

  state_e state;

  // side length fed to the next layer
  dim_t cur_dim;

  // divider working set
  dim_t rem;
  dim_t quo;
  dim_t div_stride;
  dim_t div_dim;

  logic accept;
  logic is_window;
  logic kern_err;
  logic start_div;
  dim_t quick_dim;

  //////////////////////////////
  // accept side
  //////////////////////////////

  assign in_ready  = (state == st_idle);
  assign out_valid = (state == st_hold);
  assign accept    = in_valid & in_ready;

  // conv and pool shrink the map, pending codes never match here
  assign is_window = (in_cmd.layer_type == lt_conv) | (in_cmd.layer_type == lt_pool);
  assign kern_err  = is_window & (dim_t'(in_cmd.kernel) > cur_dim);
  assign start_div = is_window & ~kern_err;

  // result for layers that skip the divider
  // shape error keeps the current length
  assign quick_dim = (in_cmd.layer_type == lt_fc) ? dim_t'(1) : cur_dim;

  // floor((in - k) / s) + 1
  assign div_dim = quo + dim_t'(1);

  //////////////////////////////
  // FSM and dimension register
  //////////////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state   <= st_idle;
      cur_dim <= dim_t'(`CU_DIM_INIT);
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            if (in_cmd.is_set_dim) begin
              // new input length, no command out
              cur_dim <= in_cmd.dim;
            end else if (start_div) begin
              state <= st_divide;
            end else begin
              state   <= st_hold;
              cur_dim <= quick_dim;
            end
          end
        end
        st_divide: begin
          if (rem < div_stride) begin
            state   <= st_hold;
            cur_dim <= div_dim;
          end
        end
        st_hold: begin
          // held until the engines take it
          if (out_ready) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  //////////////////////////////
  // command and divider data
  //////////////////////////////

  always_ff @(posedge clk) begin
    case (state)
      st_idle: begin
        if (accept && !in_cmd.is_set_dim) begin
          out_cmd.layer_type <= in_cmd.layer_type;
          out_cmd.kernel     <= in_cmd.kernel;
          out_cmd.stride     <= in_cmd.stride;
          out_cmd.relu_en    <= in_cmd.relu_en;
          out_cmd.pool_en    <= in_cmd.pool_en;
          out_cmd.illegal    <= in_cmd.illegal;
          out_cmd.shape_err  <= kern_err;
          out_cmd.in_dim     <= cur_dim;
          // overwritten at the end of a divide
          out_cmd.out_dim    <= quick_dim;
          // only meaningful when start_div
          rem        <= cur_dim - dim_t'(in_cmd.kernel);
          quo        <= '0;
          div_stride <= dim_t'(in_cmd.stride);
        end
      end
      st_divide: begin
        // one subtraction per cycle
        if (rem >= div_stride) begin
          rem <= rem - div_stride;
          quo <= quo + dim_t'(1);
        end else begin
          out_cmd.out_dim <= div_dim;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/cu_top.sv ====
`default_nettype none

module cu_top (
  input  logic               clk,
  input  logic               rst,
  // host instruction port
  input  logic               inst_valid,
  output logic               inst_ready,
  input  cu_pkg::inst_u      inst,
  // layer commands to the engines
  output logic               cmd_valid,
  input  logic               cmd_ready,
  output cu_pkg::layer_cmd_s cmd
);

  import cu_pkg::*;

  // queue -> decode
  logic     fifo_valid;
  logic     fifo_ready;
  inst_u    fifo_word;

  // decode -> shape
  logic     dec_valid;
  logic     dec_ready;
  dec_cmd_s dec_cmd;

  //////////////////////////////
  // pipeline stages
  //////////////////////////////

  // absorbs host bursts while shape divides
  cu_inst_fifo i_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (inst_valid),
    .in_ready  (inst_ready),
    .in_word   (inst),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready),
    .out_word  (fifo_word)
  );

  cu_inst_decode i_decode (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (fifo_valid),
    .in_ready  (fifo_ready),
    .in_word   (fifo_word),
    .out_valid (dec_valid),
    .out_ready (dec_ready),
    .out_cmd   (dec_cmd)
  );

  // side length chaining and output length
  cu_shape_calc i_shape (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (dec_valid),
    .in_ready  (dec_ready),
    .in_cmd    (dec_cmd),
    .out_valid (cmd_valid),
    .out_ready (cmd_ready),
    .out_cmd   (cmd)
  );

endmodule

`default_nettype wire

// ==== verif/cu_tb.sv ====
`default_nettype none
`include "cu_defs.svh"

module cu_tb;

  import cu_pkg::*;

  // directed words, upper bound
  localparam int n_dir = 20;
  // random burst length
  localparam int n_rand = 200;
  localparam int wd_cycles = (n_dir + n_rand) * 40 + 200;

  logic       clk;
  logic       rst;
  logic       inst_valid;
  inst_u      inst;
  logic       inst_ready;
  logic       cmd_valid;
  logic       cmd_ready = 1'b1;
  layer_cmd_s cmd;

  integer seed = 32'h97bf_6deb;

  // error counters, assertions and end of run
  int errors = 0;
  int end_errors = 0;

  // layer words accepted, commands taken
  int n_layer = 0;
  int n_cmd = 0;
  int full_cycles;

  logic       took;
  logic       rand_ready;
  layer_cmd_s last_cmd;

  // reference model state
  dim_t       model_dim;
  layer_cmd_s exp_q[$];
  layer_cmd_s exp_head = '0;
  int         exp_avail = 0;

  // pre-drawn burst
  inst_u rand_words [n_rand];
  logic  rand_gap [n_rand];

  cu_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .inst       (inst),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd        (cmd)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // word builders and model
  //////////////////////////////

  function automatic inst_u layer_word(input logic [`CU_TYPE_W-1:0] t, input kern_t k,
                                       input stride_t s, input logic relu, input logic pool);
    inst_u w;
    w = '0;
    w.layer.layer_type = layer_type_e'(t);
    w.layer.kernel     = k;
    w.layer.stride     = s;
    w.layer.relu_en    = relu;
    w.layer.pool_en    = pool;
    return w;
  endfunction

  function automatic inst_u dim_word(input dim_t d);
    inst_u w;
    w = '0;
    w.dim.layer_type = lt_set_dim;
    w.dim.dim        = d;
    return w;
  endfunction

  // expected command straight from the output-length rule
  task automatic model_word(input inst_u w);
    layer_cmd_s e;
    dim_t       s;
    if (w.layer.layer_type == lt_set_dim) begin
      model_dim = w.dim.dim;
    end else begin
      s = (w.layer.stride == '0) ? dim_t'(1) : dim_t'(w.layer.stride);
      e = '0;
      e.layer_type = w.layer.layer_type;
      e.kernel     = w.layer.kernel;
      e.stride     = stride_t'(s);
      e.relu_en    = w.layer.relu_en;
      e.pool_en    = w.layer.pool_en;
      e.illegal    = !(w.layer.layer_type inside {lt_conv, lt_pool, lt_relu, lt_fc, lt_bypass});
      e.in_dim     = model_dim;
      e.out_dim    = model_dim;
      if (w.layer.layer_type == lt_conv || w.layer.layer_type == lt_pool) begin
        if (dim_t'(w.layer.kernel) > model_dim) begin
          e.shape_err = 1'b1;
        end else begin
          e.out_dim = (model_dim - dim_t'(w.layer.kernel)) / s + dim_t'(1);
        end
      end else if (w.layer.layer_type == lt_fc) begin
        e.out_dim = dim_t'(1);
      end
      // shape error leaves the chain alone
      if (!e.shape_err) begin
        model_dim = e.out_dim;
      end
      exp_q.push_back(e);
      n_layer++;
    end
  endtask

  //////////////////////////////
  // host side driver
  //////////////////////////////

  // called on a falling edge, inst_ready holds until the next rise
  task automatic send_word(input inst_u w);
    logic acc;
    acc = 1'b0;
    inst = w;
    inst_valid = 1'b1;
    while (!acc) begin
      acc = inst_ready;
      @(negedge clk);
    end
    inst_valid = 1'b0;
    model_word(w);
  endtask

  task automatic wait_drain();
    while (n_cmd < n_layer) begin
      @(negedge clk);
    end
    // room for stray commands
    repeat (10) @(negedge clk);
  endtask

  //////////////////////////////
  // engine side and monitors
  //////////////////////////////

  always @(posedge clk) begin
    took     <= cmd_valid & cmd_ready;
    last_cmd <= cmd;
    if (rst) begin
      full_cycles <= 0;
    end else if (!inst_ready) begin
      full_cycles <= full_cycles + 1;
    end
  end

  // retire taken commands, then drive the next ready
  always @(negedge clk) begin
    if (took) begin
      n_cmd++;
      if (exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
    end
    exp_avail = exp_q.size();
    if (exp_q.size() != 0) begin
      exp_head = exp_q[0];
    end
    cmd_ready = rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  a_reset_state: assert property (@(posedge clk) $fell(rst) |-> inst_ready && !cmd_valid)
    else begin
      errors++;
      $display("FAIL t=%0t inst_ready,cmd_valid: got %b%b exp 10", $time, inst_ready, cmd_valid);
    end

  a_cmd_expected: assert property (@(posedge clk) disable iff (rst)
      cmd_valid && cmd_ready |-> exp_avail != 0)
    else begin
      errors++;
      $display("t=%0t: a command left with no layer word waiting for it", $time);
    end

  a_cmd_match: assert property (@(posedge clk) disable iff (rst)
      cmd_valid && cmd_ready && exp_avail != 0 |-> cmd == exp_head)
    else begin
      errors++;
      $display("FAIL t=%0t cmd: got %h exp %h", $time, cmd, exp_head);
    end

  // held command under back-pressure
  a_valid_hold: assert property (@(posedge clk) disable iff (rst)
      cmd_valid && !cmd_ready |=> cmd_valid)
    else begin
      errors++;
      $display("FAIL t=%0t cmd_valid: got %b exp 1", $time, $sampled(cmd_valid));
    end

  a_cmd_hold: assert property (@(posedge clk) disable iff (rst)
      cmd_valid && !cmd_ready |=> $stable(cmd))
    else begin
      errors++;
      $display("FAIL t=%0t cmd: got %h exp %h", $time, $sampled(cmd), $sampled(last_cmd));
    end

  a_err_keeps_dim: assert property (@(posedge clk) disable iff (rst)
      cmd_valid && (cmd.shape_err || cmd.illegal) |-> cmd.out_dim == cmd.in_dim)
    else begin
      errors++;
      $display("FAIL t=%0t cmd.out_dim: got %0d exp %0d", $time, cmd.out_dim, cmd.in_dim);
    end

  //////////////////////////////
  // sequence
  //////////////////////////////

  initial begin : main
    inst_u w;
    int    r;
    rst = 1'b1;
    inst_valid = 1'b0;
    inst = '0;
    rand_ready = 1'b0;
    model_dim = dim_t'(`CU_DIM_INIT);
    // burst drawn up front, small set-dim lengths keep divides short
    for (int i = 0; i < n_rand; i++) begin
      r = $random(seed);
      w = inst_u'(r[15:0]);
      if (r[19:16] == 4'd0 || w.layer.layer_type == lt_set_dim) begin
        w = dim_word(dim_t'(r[25:20]) + dim_t'(8));
      end
      rand_words[i] = w;
      rand_gap[i] = (r[31:30] == 2'b00);
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // chain 28 -> 26 -> 13 -> 1
    send_word(dim_word(28));
    send_word(layer_word(lt_conv, 3, 1, 1'b1, 1'b0));
    send_word(layer_word(lt_pool, 2, 2, 1'b0, 1'b1));
    send_word(layer_word(lt_fc, 0, 1, 1'b0, 1'b0));
    // kernel over the map, relu shows the length kept
    send_word(dim_word(10));
    send_word(layer_word(lt_conv, 12, 1, 1'b0, 1'b0));
    send_word(layer_word(lt_relu, 0, 0, 1'b1, 1'b0));
    // stride 0 acts as 1
    send_word(layer_word(lt_conv, 3, 0, 1'b0, 1'b0));
    // pending type codes
    for (int t = 5; t < 15; t++) begin
      send_word(layer_word(t[3:0], kern_t'(t), 2, 1'b1, 1'b0));
    end
    send_word(layer_word(lt_bypass, 1, 1, 1'b0, 1'b1));
    wait_drain();

    // random burst under random back-pressure
    rand_ready = 1'b1;
    for (int i = 0; i < n_rand; i++) begin
      if (rand_gap[i]) begin
        @(negedge clk);
      end
      send_word(rand_words[i]);
    end
    rand_ready = 1'b0;
    wait_drain();

    a_queue_filled: assert (full_cycles != 0)
      else begin
        end_errors++;
        $display("inst_ready never fell, the queue did not fill");
      end
    a_cmd_count: assert (n_cmd == n_layer)
      else begin
        end_errors++;
        $display("FAIL t=%0t command count: got %0d exp %0d", $time, n_cmd, n_layer);
      end
    $display("errors: assertions %0d, end of run %0d", errors, end_errors);
    if (errors == 0 && end_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (wd_cycles) @(posedge clk);
    $display("run still busy after %0d cycles, stopped by the watchdog", wd_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+rtl
rtl/cu_pkg.sv
rtl/cu_inst_fifo.sv
rtl/cu_inst_decode.sv
rtl/cu_shape_calc.sv
rtl/cu_top.sv
verif/cu_tb.sv

// ==== Makefile ====
# Verilator flow for the layer-command front end
# sim passes only when the log holds the pass line

TOP = cu_tb

.PHONY: all lint sim clean

all: sim

# RTL top only, testbench is parsed but not elaborated
lint:
	verilator --lint-only --timing -f tb.f --top-module cu_top

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
